// ==== logic/lsu_defines.svh ====
`ifndef LSU_DEFINES_SVH
`define LSU_DEFINES_SVH

// datapath widths.
`define LSU_DATA_WIDTH 32
`define LSU_ADDR_WIDTH 32

// data memory window and geometry.
`define RAM_BASE        32'h8000_0000
`define RAM_DEPTH_WORDS 256

// cycles from request edge to completion pulse.
`define RAM_LATENCY 2

// simple-bus response codes.
`define SB_RESP_OKAY   2'd0
`define SB_RESP_DECERR 2'd3

`endif

// ==== logic/lsu_pkg.sv ====
`include "lsu_defines.svh"

package lsu_pkg;

    typedef logic [`LSU_DATA_WIDTH-1:0]   word_t;
    typedef logic [`LSU_ADDR_WIDTH-1:0]   addr_t;
    typedef logic [`LSU_DATA_WIDTH/8-1:0] byte_mask_t;

    // bit 0 byte, bit 1 halfword, bit 2 word.
    typedef logic [2:0] size_onehot_t;
    // bit 0 selects 8-bit, bit 1 selects 16-bit.
    typedef logic [1:0] ext_width_t;
    typedef logic [1:0] resp_t;

    typedef struct packed {
        logic       req;
        addr_t      addr;
        word_t      data;
        byte_mask_t mask;
    } sb_wr_req_t;

    typedef struct packed {
        resp_t resp;
        logic  complete;
    } sb_wr_rsp_t;

    typedef struct packed {
        logic  req;
        addr_t addr;
    } sb_rd_req_t;

    typedef struct packed {
        word_t data;
        resp_t resp;
        logic  complete;
    } sb_rd_rsp_t;

    typedef enum logic {
        IDLE,
        BUSY
    } ram_chan_state_t;

endpackage

// ==== logic/lsu.sv ====
`timescale 1ns/1ps
`include "lsu_defines.svh"

module lsu (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 mem_valid,
    input  logic                 mem_ren,
    input  logic                 mem_wen,
    input  lsu_pkg::addr_t       alu_result,
    input  lsu_pkg::size_onehot_t mem_wtype,
    input  lsu_pkg::size_onehot_t mem_rtype,
    input  lsu_pkg::ext_width_t  mem_zero_width,
    input  lsu_pkg::ext_width_t  mem_sext_width,
    input  lsu_pkg::word_t       mem_wdata,
    output lsu_pkg::word_t       mem_wreg,
    output logic                 mem_wcomplete,
    output logic                 mem_rvalid,
    output logic                 mem_fault,
    output lsu_pkg::sb_wr_req_t  wr_req,
    input  lsu_pkg::sb_wr_rsp_t  wr_rsp,
    output lsu_pkg::sb_rd_req_t  rd_req,
    input  lsu_pkg::sb_rd_rsp_t  rd_rsp
);

    localparam int BYTES = `LSU_DATA_WIDTH / 8;

    lsu_pkg::addr_t      waddr;
    lsu_pkg::addr_t      raddr;
    logic                is_sb;
    logic                is_sh_align;
    logic                is_sw_align;
    lsu_pkg::word_t      wdata_shift;
    lsu_pkg::byte_mask_t rmask;
    logic [7:0]          rd_byte;
    logic [15:0]         rd_half;
    lsu_pkg::word_t      sext_res;
    lsu_pkg::word_t      zero_res;
    logic                wen_q;
    logic                ren_q;

    assign waddr = (mem_valid && mem_wen) ? alu_result : '0;
    assign raddr = (mem_valid && mem_ren) ? alu_result : '0;

    // misaligned halfword and word stores get an empty mask.
    assign is_sb       = mem_wtype[0];
    assign is_sh_align = mem_wtype[1] && (waddr[0] == 1'b0);
    assign is_sw_align = mem_wtype[2] && (waddr[1:0] == 2'b00);

    assign wdata_shift = mem_wdata << {waddr[1:0], 3'b000};

    always_comb begin
        wr_req.req  = mem_wen && !wen_q;
        wr_req.addr = waddr;
        if (is_sw_align) begin
            wr_req.data = mem_wdata;
            wr_req.mask = 4'b1111;
        end else if (is_sh_align) begin
            wr_req.data = wdata_shift;
            wr_req.mask = 4'b0011 << waddr[1:0];
        end else if (is_sb) begin
            wr_req.data = wdata_shift;
            wr_req.mask = 4'b0001 << waddr[1:0];
        end else begin
            wr_req.data = '0;
            wr_req.mask = '0;
        end
    end

    assign rd_req.req  = mem_ren && !ren_q;
    assign rd_req.addr = raddr;

    assign rmask = mem_rtype[2] ? 4'b1111 :
                   mem_rtype[1] ? 4'b0011 << raddr[1:0] :
                   mem_rtype[0] ? 4'b0001 << raddr[1:0] : 4'b0000;

    always_comb begin
        rd_byte = '0;
        for (int i = 0; i < BYTES; i++) begin
            rd_byte = rd_byte | ({8{rmask[i]}} & rd_rsp.data[8*i +: 8]);
        end
    end

    // a halfword straddling the pairs reads as zero.
    assign rd_half = (rmask[1] && rmask[0]) ? rd_rsp.data[15:0]  :
                     (rmask[3] && rmask[2]) ? rd_rsp.data[31:16] : 16'h0000;

    assign sext_res = ({32{mem_sext_width[0]}} & {{24{rd_byte[7]}}, rd_byte}) |
                      ({32{mem_sext_width[1]}} & {{16{rd_half[15]}}, rd_half});
    assign zero_res = ({32{mem_zero_width[0]}} & {24'h0, rd_byte}) |
                      ({32{mem_zero_width[1]}} & {16'h0, rd_half});

    assign mem_wreg = (mem_sext_width != '0) ? sext_res :
                      (mem_zero_width != '0) ? zero_res : rd_rsp.data;

    always_ff @(posedge clk) begin
        if (rst) begin
            wen_q <= 1'b0;
            ren_q <= 1'b0;
        end else begin
            wen_q <= mem_wen;
            ren_q <= mem_ren;
        end
    end

    assign mem_wcomplete = wr_rsp.complete;
    assign mem_rvalid    = rd_rsp.complete;
    assign mem_fault     = (wr_rsp.complete && (wr_rsp.resp != `SB_RESP_OKAY)) ||
                           (rd_rsp.complete && (rd_rsp.resp != `SB_RESP_OKAY));

    a_one_enable: assert property (@(posedge clk) disable iff (rst)
        mem_valid |-> !(mem_ren && mem_wen))
        else $error("lsu: read and write enables high together");

    a_one_ext: assert property (@(posedge clk) disable iff (rst)
        !((mem_sext_width != '0) && (mem_zero_width != '0)))
        else $error("lsu: sign and zero extension both selected");

endmodule

// ==== logic/simplebus_ram.sv ====
`timescale 1ns/1ps
`include "lsu_defines.svh"

module simplebus_ram (
    input  logic                clk,
    input  logic                rst,
    input  lsu_pkg::sb_wr_req_t wr_req,
    output lsu_pkg::sb_wr_rsp_t wr_rsp,
    input  lsu_pkg::sb_rd_req_t rd_req,
    output lsu_pkg::sb_rd_rsp_t rd_rsp
);

    localparam int BYTES = `LSU_DATA_WIDTH / 8;
    localparam int IDX_W = $clog2(`RAM_DEPTH_WORDS);
    localparam int CNT_W = $clog2(`RAM_LATENCY + 1);
    localparam logic [CNT_W-1:0] LAT = CNT_W'(`RAM_LATENCY);
    localparam lsu_pkg::addr_t RAM_END = `RAM_BASE + 4 * `RAM_DEPTH_WORDS;

    lsu_pkg::word_t           mem [`RAM_DEPTH_WORDS];
    lsu_pkg::ram_chan_state_t wr_state;
    lsu_pkg::ram_chan_state_t rd_state;
    logic [CNT_W-1:0]         wr_cnt;
    logic [CNT_W-1:0]         rd_cnt;
    lsu_pkg::sb_wr_req_t      wr_q;
    lsu_pkg::sb_rd_req_t      rd_q;
    logic                     wr_fire;
    logic                     rd_fire;

    function automatic logic in_window(lsu_pkg::addr_t addr);
        return (addr >= `RAM_BASE) && (addr < RAM_END);
    endfunction

    function automatic logic [IDX_W-1:0] word_idx(lsu_pkg::addr_t addr);
        lsu_pkg::addr_t off;
        off = addr - `RAM_BASE;
        return off[IDX_W+1:2];
    endfunction

    assign wr_fire = (wr_state == lsu_pkg::BUSY) && (wr_cnt == LAT);
    assign rd_fire = (rd_state == lsu_pkg::BUSY) && (rd_cnt == LAT);

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_state        <= lsu_pkg::IDLE;
            wr_cnt          <= '0;
            wr_rsp.complete <= 1'b0;
            rd_state        <= lsu_pkg::IDLE;
            rd_cnt          <= '0;
            rd_rsp.complete <= 1'b0;
        end else begin
            wr_rsp.complete <= wr_fire;
            rd_rsp.complete <= rd_fire;
            if (wr_state == lsu_pkg::IDLE) begin
                if (wr_req.req) begin
                    wr_state <= lsu_pkg::BUSY;
                    wr_cnt   <= CNT_W'(1);
                end
            end else if (wr_fire) begin
                wr_state <= lsu_pkg::IDLE;
            end else begin
                wr_cnt <= wr_cnt + 1'b1;
            end
            if (rd_state == lsu_pkg::IDLE) begin
                if (rd_req.req) begin
                    rd_state <= lsu_pkg::BUSY;
                    rd_cnt   <= CNT_W'(1);
                end
            end else if (rd_fire) begin
                rd_state <= lsu_pkg::IDLE;
            end else begin
                rd_cnt <= rd_cnt + 1'b1;
            end
        end
    end

    // request capture and the array access itself.
    always_ff @(posedge clk) begin
        if (wr_req.req) begin
            wr_q <= wr_req;
        end
        if (rd_req.req) begin
            rd_q <= rd_req;
        end
        if (wr_fire) begin
            wr_rsp.resp <= in_window(wr_q.addr) ? `SB_RESP_OKAY : `SB_RESP_DECERR;
            for (int i = 0; i < BYTES; i++) begin
                if (in_window(wr_q.addr) && wr_q.mask[i]) begin
                    mem[word_idx(wr_q.addr)][8*i +: 8] <= wr_q.data[8*i +: 8];
                end
            end
        end
        if (rd_fire) begin
            rd_rsp.resp <= in_window(rd_q.addr) ? `SB_RESP_OKAY : `SB_RESP_DECERR;
            rd_rsp.data <= in_window(rd_q.addr) ? mem[word_idx(rd_q.addr)] : '0;
        end
    end

    a_wr_idle: assert property (@(posedge clk) disable iff (rst)
        wr_req.req |-> wr_state == lsu_pkg::IDLE)
        else $error("simplebus_ram: write request while write channel busy");

    a_rd_idle: assert property (@(posedge clk) disable iff (rst)
        rd_req.req |-> rd_state == lsu_pkg::IDLE)
        else $error("simplebus_ram: read request while read channel busy");

endmodule

// ==== logic/lsu_top.sv ====
`timescale 1ns/1ps

module lsu_top (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  mem_valid,
    input  logic                  mem_ren,
    input  logic                  mem_wen,
    input  lsu_pkg::addr_t        alu_result,
    input  lsu_pkg::size_onehot_t mem_wtype,
    input  lsu_pkg::size_onehot_t mem_rtype,
    input  lsu_pkg::ext_width_t   mem_zero_width,
    input  lsu_pkg::ext_width_t   mem_sext_width,
    input  lsu_pkg::word_t        mem_wdata,
    output lsu_pkg::word_t        mem_wreg,
    output logic                  mem_wcomplete,
    output logic                  mem_rvalid,
    output logic                  mem_fault
);

    lsu_pkg::sb_wr_req_t wr_req;
    lsu_pkg::sb_wr_rsp_t wr_rsp;
    lsu_pkg::sb_rd_req_t rd_req;
    lsu_pkg::sb_rd_rsp_t rd_rsp;

    lsu lsu_inst (
        .clk            (clk),
        .rst            (rst),
        .mem_valid      (mem_valid),
        .mem_ren        (mem_ren),
        .mem_wen        (mem_wen),
        .alu_result     (alu_result),
        .mem_wtype      (mem_wtype),
        .mem_rtype      (mem_rtype),
        .mem_zero_width (mem_zero_width),
        .mem_sext_width (mem_sext_width),
        .mem_wdata      (mem_wdata),
        .mem_wreg       (mem_wreg),
        .mem_wcomplete  (mem_wcomplete),
        .mem_rvalid     (mem_rvalid),
        .mem_fault      (mem_fault),
        .wr_req         (wr_req),
        .wr_rsp         (wr_rsp),
        .rd_req         (rd_req),
        .rd_rsp         (rd_rsp)
    );

    // data memory on the simple bus.
    simplebus_ram ram_inst (
        .clk    (clk),
        .rst    (rst),
        .wr_req (wr_req),
        .wr_rsp (wr_rsp),
        .rd_req (rd_req),
        .rd_rsp (rd_rsp)
    );

endmodule

// ==== verif/lsu_tb.sv ====
`timescale 1ns/1ps
`include "lsu_defines.svh"

module lsu_tb;

    localparam int MAX_LINES = 64;

    logic                  clk;
    logic                  rst;
    logic                  mem_valid;
    logic                  mem_ren;
    logic                  mem_wen;
    lsu_pkg::addr_t        alu_result;
    lsu_pkg::size_onehot_t mem_wtype;
    lsu_pkg::size_onehot_t mem_rtype;
    lsu_pkg::ext_width_t   mem_zero_width;
    lsu_pkg::ext_width_t   mem_sext_width;
    lsu_pkg::word_t        mem_wdata;
    lsu_pkg::word_t        mem_wreg;
    logic                  mem_wcomplete;
    logic                  mem_rvalid;
    logic                  mem_fault;

    logic [7:0]            op_list    [MAX_LINES];
    lsu_pkg::addr_t        addr_list  [MAX_LINES];
    lsu_pkg::word_t        wdata_list [MAX_LINES];
    lsu_pkg::size_onehot_t size_list  [MAX_LINES];
    lsu_pkg::ext_width_t   sext_list  [MAX_LINES];
    lsu_pkg::ext_width_t   zext_list  [MAX_LINES];
    lsu_pkg::word_t        load_list  [MAX_LINES];
    logic                  fault_list [MAX_LINES];
    int                    n_lines;
    logic                  trace_loaded;

    lsu_top lsu_top_inst (.*);

    initial begin
        clk = 1'b0;
        forever begin
            #5 clk = ~clk;
        end
    end

    task automatic stop_with_failure(input string why);
        $display("%s", why);
        $display("Finished with errors");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_word(input string name, input lsu_pkg::word_t exp,
                              input lsu_pkg::word_t act);
        if (act !== exp) begin
            stop_with_failure($sformatf("CHECK FAILED at %0t: %s expected %h, got %h",
                                        $time, name, exp, act));
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            stop_with_failure($sformatf("CHECK FAILED at %0t: %s expected %b, got %b",
                                        $time, name, exp, act));
        end
    endtask

    // lines that start with # are column notes.
    task automatic read_trace();
        int    fd;
        int    got;
        string line;
        fd = $fopen("verif/lsu_trace.txt", "r");
        if (fd == 0) begin
            stop_with_failure("cannot open the trace file verif/lsu_trace.txt");
        end
        n_lines = 0;
        while ($fgets(line, fd) != 0) begin
            if (line.len() > 1 && line[0] != "#") begin
                if (n_lines == MAX_LINES) begin
                    stop_with_failure("the trace file holds more accesses than the testbench");
                end
                got = $sscanf(line, "%c %h %h %b %b %b %h %b", op_list[n_lines],
                              addr_list[n_lines], wdata_list[n_lines], size_list[n_lines],
                              sext_list[n_lines], zext_list[n_lines], load_list[n_lines],
                              fault_list[n_lines]);
                if (got != 8 || (op_list[n_lines] != "R" && op_list[n_lines] != "W")) begin
                    stop_with_failure($sformatf("trace line %0d cannot be parsed", n_lines));
                end
                n_lines++;
            end
        end
        $fclose(fd);
        if (n_lines == 0) begin
            stop_with_failure("the trace file holds no accesses");
        end
    endtask

    // called at a falling edge; the next rising edge is the request edge.
    task automatic run_access(input int idx);
        int   cycles;
        logic is_read;
        is_read        = (op_list[idx] == "R");
        mem_valid      = 1'b1;
        mem_ren        = is_read;
        mem_wen        = !is_read;
        alu_result     = addr_list[idx];
        mem_wdata      = wdata_list[idx];
        mem_wtype      = is_read ? '0 : size_list[idx];
        mem_rtype      = is_read ? size_list[idx] : '0;
        mem_sext_width = sext_list[idx];
        mem_zero_width = zext_list[idx];
        cycles         = 0;
        @(negedge clk);
        while (!(is_read ? mem_rvalid : mem_wcomplete)) begin
            cycles++;
            if (cycles > `RAM_LATENCY) begin
                stop_with_failure($sformatf("access %0d got no completion within %0d cycles",
                                            idx, `RAM_LATENCY));
            end
            @(negedge clk);
        end
        if (cycles != `RAM_LATENCY) begin
            stop_with_failure($sformatf("access %0d completed %0d cycles after the request, not %0d",
                                        idx, cycles, `RAM_LATENCY));
        end
        if (is_read) begin
            check_word("mem_wreg", load_list[idx], mem_wreg);
        end
        check_bit("mem_fault", fault_list[idx], mem_fault);
        mem_valid = 1'b0;
        mem_ren   = 1'b0;
        mem_wen   = 1'b0;
        @(negedge clk);
        // completion is a single-cycle pulse.
        check_bit(is_read ? "mem_rvalid" : "mem_wcomplete", 1'b0,
                  is_read ? mem_rvalid : mem_wcomplete);
    endtask

    initial begin
        rst            = 1'b1;
        mem_valid      = 1'b0;
        mem_ren        = 1'b0;
        mem_wen        = 1'b0;
        alu_result     = '0;
        mem_wtype      = '0;
        mem_rtype      = '0;
        mem_zero_width = '0;
        mem_sext_width = '0;
        mem_wdata      = '0;
        trace_loaded   = 1'b0;
        read_trace();
        trace_loaded = 1'b1;
        repeat (10) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        @(negedge clk);
        for (int i = 0; i < n_lines; i++) begin
            run_access(i);
        end
        $display("Finished with no errors");
        $finish;
    end

    // twice the expected run length plus the reset time.
    initial begin
        wait (trace_loaded);
        #(n_lines * (`RAM_LATENCY + 4) * 10 * 2 + 100);
        stop_with_failure("watchdog expired before the trace was finished");
    end

endmodule

// ==== build.f ====
+incdir+logic
logic/lsu_pkg.sv
logic/lsu.sv
logic/simplebus_ram.sv
logic/lsu_top.sv
verif/lsu_tb.sv

// ==== run.sh ====
#!/bin/sh
# builds the testbench with Verilator and runs it from the project root.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f build.f --top-module lsu_tb -o Vlsu_tb
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/Vlsu_tb
status=$?
if [ $status -ne 0 ]; then
    echo "simulation failed with status $status"
    exit $status
fi
exit 0

// ==== verif/lsu_trace.txt ====
# op addr wdata size sext zext expected_load expected_fault (hex, hex, hex, bin, bin, bin, hex, bin)
# size bit 2 word, bit 1 halfword, bit 0 byte; sext and zext bit 1 16-bit, bit 0 8-bit
W 80000000 deadbeef 100 00 00 00000000 0
R 80000000 00000000 100 00 00 deadbeef 0
W 80000004 12345678 100 00 00 00000000 0
R 80000004 00000000 100 00 00 12345678 0
W 80000010 11223344 100 00 00 00000000 0
W 80000010 000000aa 001 00 00 00000000 0
R 80000010 00000000 100 00 00 112233aa 0
W 80000011 000077bb 001 00 00 00000000 0
R 80000010 00000000 100 00 00 1122bbaa 0
W 80000012 ffffffcc 001 00 00 00000000 0
W 80000013 123456dd 001 00 00 00000000 0
R 80000010 00000000 100 00 00 ddccbbaa 0
W 80000020 cafef00d 100 00 00 00000000 0
W 80000022 0000beef 010 00 00 00000000 0
R 80000020 00000000 100 00 00 beeff00d 0
W 80000020 00001234 010 00 00 00000000 0
R 80000020 00000000 100 00 00 beef1234 0
R 80000010 00000000 001 01 00 ffffffaa 0
R 80000010 00000000 001 00 01 000000aa 0
R 80000011 00000000 001 01 00 ffffffbb 0
R 80000012 00000000 001 00 01 000000cc 0
R 80000013 00000000 001 01 00 ffffffdd 0
R 80000005 00000000 001 01 00 00000056 0
R 80000010 00000000 010 10 00 ffffbbaa 0
R 80000012 00000000 010 00 10 0000ddcc 0
R 80000006 00000000 010 10 00 00001234 0
R 80000011 00000000 010 10 00 00000000 0
R 80000013 00000000 010 00 10 00000000 0
W 80000030 01020304 100 00 00 00000000 0
W 80000031 ffffffff 010 00 00 00000000 0
W 80000032 ffffffff 100 00 00 00000000 0
R 80000030 00000000 100 00 00 01020304 0
W 00000000 ffffffff 100 00 00 00000000 1
R 80000000 00000000 100 00 00 deadbeef 0
R 00001000 00000000 100 00 00 00000000 1
W 80000400 12345678 100 00 00 00000000 1
R 80000400 00000000 100 00 00 00000000 1
W 800003fc a5a5a5a5 100 00 00 00000000 0
R 800003fc 00000000 100 00 00 a5a5a5a5 0
